//--- compile.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/datapath_pkg.sv
rtl/code_rom.sv
rtl/fetch_unit.sv
rtl/ram_access.sv
rtl/data_memory.sv
rtl/alu_core.sv
rtl/mcu_datapath.sv
verification/tb_mcu_datapath.sv

//--- rtl/alu_core.sv
module alu_core
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       alu_load,
    input  alu_op_e    alu_op,
    input  byte_t      op_a,
    input  byte_t      op_b,
    input  byte_t      imm,
    input  logic       use_imm,
    input  logic       carry_in,
    output byte_t      result,
    output alu_flags_t flags
);

    byte_t      src_b;
    logic [8:0] wide;
    logic [4:0] nib;
    byte_t      next_result;
    alu_flags_t next_flags;

    // Immediate or RAM data as second operand
    assign src_b = use_imm ? imm : op_b;

    // --------------------------------------------------
    // Operation decode
    // --------------------------------------------------
    always_comb begin
        next_result = result;
        next_flags  = flags;
        wide        = '0;
        nib         = '0;
        case (alu_op)
            ALU_ADD: begin
                wide          = {1'b0, op_a} + {1'b0, src_b};
                nib           = {1'b0, op_a[3:0]} + {1'b0, src_b[3:0]};
                next_result   = wide[7:0];
                next_flags.cy = wide[8];
                next_flags.ac = nib[4];
                // Same input signs, result sign differs
                next_flags.ov = (op_a[7] == src_b[7]) && (wide[7] != op_a[7]);
            end
            ALU_SUBB: begin
                wide          = {1'b0, op_a} - {1'b0, src_b} - {8'b0, carry_in};
                nib           = {1'b0, op_a[3:0]} - {1'b0, src_b[3:0]} - {4'b0, carry_in};
                next_result   = wide[7:0];
                next_flags.cy = wide[8];
                next_flags.ac = nib[4];
                next_flags.ov = (op_a[7] != src_b[7]) && (wide[7] != op_a[7]);
            end
            ALU_ANL: next_result = op_a & src_b;
            ALU_ORL: next_result = op_a | src_b;
            ALU_XRL: next_result = op_a ^ src_b;
            ALU_INC: next_result = op_a + byte_t'(1);
            ALU_DEC: next_result = op_a - byte_t'(1);
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            flags  <= '0;
        end else if (alu_load) begin
            result <= next_result;
            flags  <= next_flags;
        end
    end

endmodule

//--- rtl/code_rom.sv
`include "mcu_defs.svh"

module code_rom
    import datapath_pkg::*;
(
    input  logic       clock,
    input  logic       prog_wr,
    input  byte_t      prog_addr,
    input  byte_t      prog_data,
    input  code_addr_t pc,
    output byte_t      rom_data
);

    localparam int ROM_AW = $clog2(`MCU_CODE_DEPTH);

    byte_t mem [`MCU_CODE_DEPTH];

    // Program load port
    always_ff @(posedge clock) begin
        if (prog_wr) begin
            mem[prog_addr[ROM_AW-1:0]] <= prog_data;
        end
    end

    // Outside the ROM the fetch sees zero
    assign rom_data = (pc < `MCU_CODE_DEPTH) ? mem[pc[ROM_AW-1:0]] : '0;

endmodule

//--- rtl/data_memory.sv
`include "mcu_defs.svh"

module data_memory
    import datapath_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  ram_req_t   req,
    input  alu_flags_t flags,
    output byte_t      rd_data,
    output byte_t      acc,
    output byte_t      psw,
    output byte_t      port2_data
);

    localparam int IRAM_AW = $clog2(`MCU_IRAM_DEPTH);

    byte_t iram [`MCU_IRAM_DEPTH];
    byte_t p2;
    logic  in_iram;

    assign in_iram = (req.addr < `MCU_IRAM_DEPTH);

    // --------------------------------------------------
    // Internal RAM
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (req.wr && in_iram) begin
            iram[req.addr[IRAM_AW-1:0]] <= req.wdata;
        end
    end

    // --------------------------------------------------
    // SFRs: ACC, PSW and P2
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            psw <= '0;
            p2  <= '0;
        end else begin
            if (req.wr && !in_iram) begin
                case (req.addr)
                    `MCU_SFR_ACC: acc <= req.wdata;
                    `MCU_SFR_PSW: psw <= req.wdata;
                    `MCU_SFR_P2:  p2  <= req.wdata;
                    default: begin
                    end
                endcase
            end
            // Arithmetic flags, RS bits untouched
            if (req.flag_wr) begin
                psw[`MCU_PSW_CY] <= flags.cy;
                psw[`MCU_PSW_AC] <= flags.ac;
                psw[`MCU_PSW_OV] <= flags.ov;
            end
        end
    end

    // Read mux
    always_comb begin
        if (in_iram) begin
            rd_data = iram[req.addr[IRAM_AW-1:0]];
        end else begin
            case (req.addr)
                `MCU_SFR_ACC: rd_data = acc;
                `MCU_SFR_PSW: rd_data = psw;
                `MCU_SFR_P2:  rd_data = p2;
                default:      rd_data = '0;
            endcase
        end
    end

    assign port2_data = p2;

endmodule

//--- rtl/datapath_pkg.sv
`include "mcu_defs.svh"

package datapath_pkg;

    import isa_pkg::*;

    // --------------------------------------------------
    // Basic data types
    // --------------------------------------------------
    typedef logic [`MCU_DATA_W-1:0]  byte_t;
    typedef logic [`MCU_CODE_AW-1:0] code_addr_t;

    // Strobes and codes from the controller
    typedef struct packed {
        logic        ir_load;
        logic        pc_load;
        logic        alu_load;
        logic        a_load;
        logic        ram_load;
        logic        jmp_load;
        ram_access_e ram_access;
        alu_op_e     alu_op;
    } ctrl_t;

    // Registered RAM / SFR request
    typedef struct packed {
        byte_t addr;
        byte_t wdata;
        logic  wr;
        logic  flag_wr;
    } ram_req_t;

    // ALU status flags
    typedef struct packed {
        logic cy;
        logic ac;
        logic ov;
    } alu_flags_t;

endpackage

//--- rtl/fetch_unit.sv
`include "mcu_defs.svh"

module fetch_unit
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  ctrl_t      ctrl,
    input  byte_t      rom_data,
    input  byte_t      acc,
    output code_addr_t pc,
    output byte_t      opcode,
    output byte_t      operand
);

    byte_t      ir;
    logic       jump_taken;
    code_addr_t jump_target;

    // --------------------------------------------------
    // Jump resolution
    // --------------------------------------------------
    always_comb begin
        jump_taken = 1'b0;
        if (ir == OPC_JZ) begin
            jump_taken = (acc == '0);
        end else if (ir == OPC_JNZ) begin
            jump_taken = (acc != '0);
        end
    end

    // Short jump, upper byte cleared
    assign jump_target = {{(`MCU_CODE_AW - `MCU_DATA_W){1'b0}}, operand};

    // --------------------------------------------------
    // PC, IR and operand registers
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            ir      <= '0;
            operand <= '0;
        end else if (ctrl.pc_load) begin
            pc <= pc + code_addr_t'(1);
            // Opcode fetch when ir_load is also set, else operand byte
            if (ctrl.ir_load) begin
                ir <= rom_data;
            end else begin
                operand <= rom_data;
            end
        end else if (ctrl.jmp_load && jump_taken) begin
            pc <= jump_target;
        end
    end

    assign opcode = ir;

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    // --------------------------------------------------
    // ALU operation selected by the controller
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUBB = 3'd2,
        ALU_ANL  = 3'd3,
        ALU_ORL  = 3'd4,
        ALU_XRL  = 3'd5,
        ALU_INC  = 3'd6,
        ALU_DEC  = 3'd7
    } alu_op_e;

    // --------------------------------------------------
    // Memory access codes
    // --------------------------------------------------
    typedef enum logic [2:0] {
        RD_RAM_IM      = 3'd0,
        RD_RAM_DIRECT  = 3'd1,
        RD_RAM_REG     = 3'd2,
        WR_RAM_DIRECT  = 3'd3,
        WR_RAM_REG     = 3'd4,
        WR_RAM_REG_IM  = 3'd5,
        RAM_IDLE       = 3'd6
    } ram_access_e;

    // Conditional jump opcodes, target in the operand byte
    localparam logic [7:0] OPC_JZ  = 8'h60;
    localparam logic [7:0] OPC_JNZ = 8'h70;

endpackage

//--- rtl/mcu_datapath.sv
`include "mcu_defs.svh"

module mcu_datapath
    import datapath_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  logic  prog_wr,
    input  byte_t prog_addr,
    input  byte_t prog_data,
    output byte_t opcode,
    output byte_t port2_data
);

    code_addr_t pc;
    byte_t      rom_data;
    byte_t      operand;
    byte_t      rd_data;
    byte_t      acc;
    byte_t      psw;
    byte_t      alu_result;
    alu_flags_t alu_flags;
    alu_flags_t wr_flags;
    ram_req_t   req;
    logic       use_imm;

    // --------------------------------------------------
    // Program memory and fetch
    // --------------------------------------------------
    code_rom u_code_rom (
        .clock     (clock),
        .prog_wr   (prog_wr),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .rom_data  (rom_data)
    );

    fetch_unit u_fetch_unit (
        .clock    (clock),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .rom_data (rom_data),
        .acc      (acc),
        .pc       (pc),
        .opcode   (opcode),
        .operand  (operand)
    );

    // --------------------------------------------------
    // Data memory path
    // --------------------------------------------------
    ram_access u_ram_access (
        .clock      (clock),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .opcode     (opcode),
        .operand    (operand),
        .rd_data    (rd_data),
        .acc        (acc),
        .psw        (psw),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .req        (req),
        .flags      (wr_flags),
        .use_imm    (use_imm)
    );

    data_memory u_data_memory (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (req),
        .flags      (wr_flags),
        .rd_data    (rd_data),
        .acc        (acc),
        .psw        (psw),
        .port2_data (port2_data)
    );

    // ACC is always the first operand
    alu_core u_alu_core (
        .clock    (clock),
        .rst_n    (rst_n),
        .alu_load (ctrl.alu_load),
        .alu_op   (ctrl.alu_op),
        .op_a     (acc),
        .op_b     (rd_data),
        .imm      (operand),
        .use_imm  (use_imm),
        .carry_in (psw[`MCU_PSW_CY]),
        .result   (alu_result),
        .flags    (alu_flags)
    );

endmodule

//--- rtl/mcu_defs.svh
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define MCU_DATA_W       8
`define MCU_CODE_AW      16

// Memory depths
`define MCU_CODE_DEPTH   256
`define MCU_IRAM_DEPTH   128

// --------------------------------------------------
// SFR addresses
// --------------------------------------------------
`define MCU_SFR_ACC      8'hE0
`define MCU_SFR_PSW      8'hD0
`define MCU_SFR_P2       8'hA0

// Bytes per register bank
`define MCU_BANK_STRIDE  8

// PSW bit positions
`define MCU_PSW_CY       7
`define MCU_PSW_AC       6
`define MCU_PSW_RS1      4
`define MCU_PSW_RS0      3
`define MCU_PSW_OV       2

`endif

//--- rtl/ram_access.sv
`include "mcu_defs.svh"

module ram_access
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  ctrl_t      ctrl,
    input  byte_t      opcode,
    input  byte_t      operand,
    input  byte_t      rd_data,
    input  byte_t      acc,
    input  byte_t      psw,
    input  byte_t      alu_result,
    input  alu_flags_t alu_flags,
    output ram_req_t   req,
    output alu_flags_t flags,
    output logic       use_imm
);

    logic [1:0] bank;
    byte_t      bank_base;
    byte_t      reg_addr;
    byte_t      commit_data;
    ram_req_t   next_req;

    // --------------------------------------------------
    // Register address within the selected bank
    // --------------------------------------------------
    assign bank      = {psw[`MCU_PSW_RS1], psw[`MCU_PSW_RS0]};
    assign bank_base = byte_t'(bank * `MCU_BANK_STRIDE);
    assign reg_addr  = bank_base + byte_t'(opcode[2:0]);

    // Accumulator commit source
    always_comb begin
        if (ctrl.alu_op != ALU_NONE) begin
            commit_data = alu_result;
        end else if (ctrl.ram_access == RD_RAM_IM) begin
            commit_data = operand;
        end else begin
            commit_data = rd_data;
        end
    end

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    always_comb begin
        // Address held between requests so read data stays valid
        next_req         = req;
        next_req.wr      = 1'b0;
        next_req.flag_wr = 1'b0;
        if (ctrl.ram_load && ctrl.a_load) begin
            next_req.addr    = `MCU_SFR_ACC;
            next_req.wdata   = commit_data;
            next_req.wr      = 1'b1;
            next_req.flag_wr = (ctrl.alu_op == ALU_ADD) || (ctrl.alu_op == ALU_SUBB);
        end else if (ctrl.ram_load) begin
            case (ctrl.ram_access)
                RD_RAM_IM, RD_RAM_DIRECT: begin
                    next_req.addr = operand;
                end
                RD_RAM_REG: begin
                    next_req.addr = reg_addr;
                end
                WR_RAM_DIRECT: begin
                    next_req.addr  = operand;
                    next_req.wdata = acc;
                    next_req.wr    = 1'b1;
                end
                WR_RAM_REG: begin
                    next_req.addr  = reg_addr;
                    next_req.wdata = acc;
                    next_req.wr    = 1'b1;
                end
                WR_RAM_REG_IM: begin
                    next_req.addr  = reg_addr;
                    next_req.wdata = operand;
                    next_req.wr    = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            req     <= '0;
            flags   <= '0;
            use_imm <= 1'b0;
        end else begin
            req <= next_req;
            if (ctrl.ram_load && ctrl.a_load) begin
                flags <= alu_flags;
            end
            // ALU second operand follows the last plain request
            if (ctrl.ram_load && !ctrl.a_load) begin
                use_imm <= (ctrl.ram_access == RD_RAM_IM);
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator
verilator --binary --timescale 1ns/1ps -Wno-fatal -f compile.f \
    --top-module tb_mcu_datapath -o tb_mcu_datapath > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_mcu_datapath > sim.log 2>&1
grep -q "Test failures found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL, run ended without a result"; exit 1; }
echo "PASS"

//--- verification/tb_mcu_datapath.sv
`include "mcu_defs.svh"

module tb_mcu_datapath
    import isa_pkg::*;
    import datapath_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    MAX_CYCLES = 20000;
    localparam byte_t JUMP_MARK  = 8'hC3;
    localparam byte_t FALL_MARK  = 8'h3C;

    logic  clock;
    logic  rst_n;
    ctrl_t ctrl;
    logic  prog_wr;
    byte_t prog_addr;
    byte_t prog_data;
    byte_t opcode;
    byte_t port2_data;

    // Controller's view of PC and PSW
    int    pc_model;
    byte_t exp_psw;
    byte_t program_image [8];

    mcu_datapath dut_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .prog_wr    (prog_wr),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .opcode     (opcode),
        .port2_data (port2_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // Watchdog for the whole run
    initial begin
        for (int i = 0; i < MAX_CYCLES; i++) begin
            @(posedge clock);
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Basic helpers
    // --------------------------------------------------
    function automatic ctrl_t idle_ctrl();
        ctrl_t c;
        c            = '0;
        c.ram_access = RAM_IDLE;
        c.alu_op     = ALU_NONE;
        return c;
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clock);
        end
    endtask

    task automatic compare_byte(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s is %02h, expected %02h", $time, name, actual,
                     expected);
            $display("Test failures found");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_room(input int addr);
        if (addr >= `MCU_CODE_DEPTH) begin
            $display("Program ROM space used up at address %0d", addr);
            $display("Test failures found");
            $fatal(1, "out of program space");
        end
    endtask

    // One cycle of strobes followed by idle
    task automatic pulse(input ctrl_t c);
        ctrl = c;
        wait_cycles(1);
        ctrl = idle_ctrl();
    endtask

    // --------------------------------------------------
    // Controller tasks
    // --------------------------------------------------
    task automatic write_rom(input byte_t addr, input byte_t data);
        prog_wr   = 1'b1;
        prog_addr = addr;
        prog_data = data;
        wait_cycles(1);
        prog_wr   = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < 8; i++) begin
            write_rom(byte_t'(i), program_image[i]);
        end
    endtask

    task automatic fetch_opcode(input byte_t expected);
        ctrl_t c;
        c         = idle_ctrl();
        c.pc_load = 1'b1;
        c.ir_load = 1'b1;
        pulse(c);
        compare_byte("opcode", opcode, expected);
        pc_model++;
    endtask

    task automatic fetch_operand();
        ctrl_t c;
        c         = idle_ctrl();
        c.pc_load = 1'b1;
        pulse(c);
        pc_model++;
    endtask

    task automatic put_opcode(input byte_t value);
        check_room(pc_model);
        write_rom(byte_t'(pc_model), value);
        fetch_opcode(value);
    endtask

    task automatic put_operand(input byte_t value);
        check_room(pc_model);
        write_rom(byte_t'(pc_model), value);
        fetch_operand();
    endtask

    // Request edge plus one cycle for the write or read data
    task automatic mem_access(input ram_access_e code);
        ctrl_t c;
        c            = idle_ctrl();
        c.ram_load   = 1'b1;
        c.ram_access = code;
        pulse(c);
        wait_cycles(1);
    endtask

    task automatic alu_step(input alu_op_e op);
        ctrl_t c;
        c          = idle_ctrl();
        c.alu_load = 1'b1;
        c.alu_op   = op;
        pulse(c);
    endtask

    task automatic commit_acc(input ram_access_e src, input alu_op_e op);
        ctrl_t c;
        c            = idle_ctrl();
        c.a_load     = 1'b1;
        c.ram_load   = 1'b1;
        c.ram_access = src;
        c.alu_op     = op;
        pulse(c);
        wait_cycles(1);
    endtask

    task automatic jump();
        ctrl_t c;
        c          = idle_ctrl();
        c.jmp_load = 1'b1;
        pulse(c);
    endtask

    // Short sequences built from the tasks above
    task automatic set_acc(input byte_t value);
        put_operand(value);
        commit_acc(RD_RAM_IM, ALU_NONE);
    endtask

    task automatic acc_to_port2();
        put_operand(`MCU_SFR_P2);
        mem_access(WR_RAM_DIRECT);
    endtask

    task automatic set_psw(input byte_t value);
        set_acc(value);
        put_operand(`MCU_SFR_PSW);
        mem_access(WR_RAM_DIRECT);
        exp_psw = value;
    endtask

    task automatic psw_to_port2();
        put_operand(`MCU_SFR_PSW);
        mem_access(RD_RAM_DIRECT);
        commit_acc(RD_RAM_DIRECT, ALU_NONE);
        acc_to_port2();
    endtask

    // --------------------------------------------------
    // Reference ALU
    // --------------------------------------------------
    function automatic byte_t alu_model(input alu_op_e op, input byte_t a, input byte_t b,
                                        input logic cin, output alu_flags_t f);
        int    full;
        int    low;
        int    sres;
        byte_t res;
        f   = '0;
        res = '0;
        case (op)
            ALU_ADD: begin
                full = int'(a) + int'(b);
                low  = int'(a[3:0]) + int'(b[3:0]);
                sres = int'($signed(a)) + int'($signed(b));
                f.cy = (full > 255);
                f.ac = (low > 15);
                f.ov = (sres > 127) || (sres < -128);
                res  = byte_t'(full);
            end
            ALU_SUBB: begin
                full = int'(a) - int'(b) - int'(cin);
                low  = int'(a[3:0]) - int'(b[3:0]) - int'(cin);
                sres = int'($signed(a)) - int'($signed(b)) - int'(cin);
                f.cy = (full < 0);
                f.ac = (low < 0);
                f.ov = (sres > 127) || (sres < -128);
                res  = byte_t'(full);
            end
            ALU_ANL: res = a & b;
            ALU_ORL: res = a | b;
            ALU_XRL: res = a ^ b;
            ALU_INC: res = a + 8'd1;
            ALU_DEC: res = a - 8'd1;
            default: res = a;
        endcase
        return res;
    endfunction

    // ACC = a op b with b from RAM or from the operand byte
    task automatic alu_through(input alu_op_e op, input byte_t a, input byte_t b,
                               input bit use_ram, output byte_t expected);
        byte_t      addr;
        alu_flags_t f;
        expected = alu_model(op, a, b, exp_psw[`MCU_PSW_CY], f);
        if (use_ram) begin
            addr = byte_t'($urandom_range(127, 32));
            set_acc(b);
            put_operand(addr);
            mem_access(WR_RAM_DIRECT);
            set_acc(a);
            put_operand(addr);
            mem_access(RD_RAM_DIRECT);
        end else begin
            set_acc(a);
            put_operand(b);
            mem_access(RD_RAM_IM);
        end
        alu_step(op);
        commit_acc(RD_RAM_DIRECT, op);
        if (op == ALU_ADD || op == ALU_SUBB) begin
            exp_psw[`MCU_PSW_CY] = f.cy;
            exp_psw[`MCU_PSW_AC] = f.ac;
            exp_psw[`MCU_PSW_OV] = f.ov;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_fetch_order();
        for (int i = 0; i < 8; i++) begin
            program_image[i] = byte_t'($urandom);
        end
        load_program();
        for (int i = 0; i < 8; i++) begin
            fetch_opcode(program_image[i]);
        end
    endtask

    task automatic test_port2_immediate();
        byte_t value;
        value = byte_t'($urandom);
        set_acc(value);
        acc_to_port2();
        compare_byte("port2_data", port2_data, value);
    endtask

    task automatic test_alu_ops();
        byte_t expected;
        for (int i = 0; i < 7; i++) begin
            alu_through(alu_op_e'(i + 1), byte_t'($urandom), byte_t'($urandom), (i % 2 == 0),
                        expected);
            acc_to_port2();
            compare_byte("port2_data", port2_data, expected);
        end
    endtask

    task automatic test_psw_flags();
        byte_t expected;
        byte_t flag_mask;
        flag_mask = byte_t'((1 << `MCU_PSW_CY) | (1 << `MCU_PSW_AC) | (1 << `MCU_PSW_OV));
        for (int i = 0; i < 6; i++) begin
            alu_through((i % 2 == 0) ? ALU_ADD : ALU_SUBB, byte_t'($urandom),
                        byte_t'($urandom), 1'b0, expected);
            psw_to_port2();
            compare_byte("psw", port2_data, exp_psw);
        end
        // PSW flags now differ from the flags held in the ALU
        set_psw(exp_psw ^ flag_mask);
        // INC must not touch the flags
        alu_through(ALU_INC, byte_t'($urandom), byte_t'($urandom), 1'b0, expected);
        psw_to_port2();
        compare_byte("psw", port2_data, exp_psw);
    endtask

    task automatic test_register_banks();
        byte_t rnd;
        byte_t r;
        byte_t data [4];
        r = byte_t'($urandom_range(7, 0));
        put_opcode(8'h78 | r);
        for (int k = 0; k < 4; k++) begin
            rnd     = byte_t'($urandom);
            data[k] = {rnd[7:2], k[1:0]};
            set_psw(byte_t'(k << `MCU_PSW_RS0));
            put_operand(data[k]);
            mem_access(WR_RAM_REG_IM);
        end
        for (int k = 0; k < 4; k++) begin
            set_psw(byte_t'(k << `MCU_PSW_RS0));
            mem_access(RD_RAM_REG);
            commit_acc(RD_RAM_REG, ALU_NONE);
            acc_to_port2();
            compare_byte("port2_data", port2_data, data[k]);
        end
        set_psw(8'h00);
    endtask

    task automatic test_jumps();
        byte_t opc;
        byte_t val;
        byte_t target;
        logic  taken;
        for (int k = 0; k < 4; k++) begin
            opc   = (k < 2) ? OPC_JZ : OPC_JNZ;
            val   = (k % 2 == 0) ? 8'h00 : byte_t'($urandom_range(255, 1));
            taken = (opc == OPC_JZ) ? (val == 8'h00) : (val != 8'h00);
            set_acc(val);
            put_opcode(opc);
            check_room(pc_model + 17);
            target = byte_t'(pc_model + 17);
            write_rom(target, JUMP_MARK);
            put_operand(target);
            write_rom(byte_t'(pc_model), FALL_MARK);
            jump();
            if (taken) begin
                pc_model = int'(target);
            end
            fetch_opcode(taken ? JUMP_MARK : FALL_MARK);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        ctrl      = idle_ctrl();
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rst_n     = 1'b0;
        pc_model  = 0;
        exp_psw   = '0;
        void'($urandom(32'h0bc3_4784));

        wait_cycles(4);
        rst_n = 1'b1;
        wait_cycles(1);
        compare_byte("opcode", opcode, 8'h00);
        compare_byte("port2_data", port2_data, 8'h00);

        test_fetch_order();
        test_port2_immediate();
        test_alu_ops();
        test_psw_flags();
        test_register_banks();
        test_jumps();

        $display("All tests passed!");
        $finish;
    end

endmodule
